// File: design/adderTree.sv
`timescale 1ns/1ns
`default_nettype none

module adderTree
    import firPkg::*;
(
    input  logic clkDS,
    input  logic rst,
    input  logic partValid,
    output logic partReady,
    input  sumT  partSums [NUM_GROUPS],
    output logic sumValid,
    input  logic sumReady,
    output sumT  total
);

    localparam int LAYERS = $clog2(NUM_GROUPS);

    // Heap order: node 1 is the root, node i has children 2i and 2i+1.
    // Children at NUM_GROUPS and above are the incoming partial sums.
    sumT node [1:NUM_GROUPS-1];
    sumT nodeNext [1:NUM_GROUPS-1];

    // Index 0 is the root layer, LAYERS-1 the layer next to the LUTs
    logic [LAYERS-1:0] levelValid;
    logic advance;

    for (genvar i = 1; i < NUM_GROUPS; i++) begin : genNode
        sumT leftIn;
        sumT rightIn;

        if (2 * i >= NUM_GROUPS) begin : genLeaf
            assign leftIn = partSums[2*i - NUM_GROUPS];
            assign rightIn = partSums[2*i + 1 - NUM_GROUPS];
        end else begin : genInner
            assign leftIn = node[2*i];
            assign rightIn = node[2*i + 1];
        end

        assign nodeNext[i] = leftIn + rightIn;
    end

    // Whole tree moves together, bubbles included
    assign advance = !levelValid[0] || sumReady;
    assign partReady = advance;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            levelValid <= '0;
        end else if (advance) begin
            levelValid[LAYERS-1] <= partValid;
            for (int d = 0; d < LAYERS - 1; d++) begin
                levelValid[d] <= levelValid[d+1];
            end
        end
    end

    always_ff @(posedge clkDS) begin
        if (advance) begin
            for (int i = 1; i < NUM_GROUPS; i++) begin
                node[i] <= nodeNext[i];
            end
        end
    end

    assign sumValid = levelValid[0];
    assign total = node[1];

endmodule

`default_nettype wire

// File: design/bitCollector.sv
`timescale 1ns/1ns
`default_nettype none

`include "firDecimator_config.svh"

module bitCollector
    import firPkg::*;
(
    input  logic   clkDS,
    input  logic   rst,
    input  logic   bitReq,
    input  logic   bitData,
    output logic   bitAck,
    output logic   winValid,
    input  logic   winReady,
    output windowT window
);

    localparam int FILL_W = $clog2(`TAPS + 1);
    localparam int PHASE_W = (`OSR > 1) ? $clog2(`OSR) : 1;

    logic [FILL_W-1:0] fillCount;
    logic [PHASE_W-1:0] phase;
    logic filled;
    logic take;
    logic emit;

    assign filled = (fillCount == FILL_W'(`TAPS));

    // New request, and no window left waiting downstream
    assign take = bitReq && !bitAck && !winValid;

    // First window on the TAPS-th bit, then one every OSR bits
    assign emit = filled ? (phase == PHASE_W'(`OSR - 1))
                         : (fillCount == FILL_W'(`TAPS - 1));

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            bitAck <= 1'b0;
            fillCount <= '0;
            phase <= '0;
            winValid <= 1'b0;
        end else begin
            if (take) begin
                bitAck <= 1'b1;
            end else if (bitAck && !bitReq) begin
                bitAck <= 1'b0;
            end

            if (take && !filled) begin
                fillCount <= fillCount + 1'b1;
            end

            if (take && filled) begin
                phase <= emit ? '0 : phase + 1'b1;
            end

            if (take && emit) begin
                winValid <= 1'b1;
            end else if (winReady) begin
                winValid <= 1'b0;
            end
        end
    end

    // History shift register
    always_ff @(posedge clkDS) begin
        if (take) begin
            window <= {window[`TAPS-2:0], bitData};
        end
    end

endmodule

`default_nettype wire

// File: design/firDecimator.sv
`timescale 1ns/1ns
`default_nettype none

module firDecimator
    import firPkg::*;
(
    input  logic clkDS,
    input  logic rst,
    input  logic bitReq,
    input  logic bitData,
    output logic bitAck,
    output logic outReq,
    input  logic outAck,
    output outT  outData
);

    logic winValid;
    logic winReady;
    windowT window;

    logic partValid;
    logic partReady;
    sumT partSums [NUM_GROUPS];

    logic sumValid;
    logic sumReady;
    sumT total;

    bitCollector collectorInst (
        .clkDS    (clkDS),
        .rst      (rst),
        .bitReq   (bitReq),
        .bitData  (bitData),
        .bitAck   (bitAck),
        .winValid (winValid),
        .winReady (winReady),
        .window   (window)
    );

    lutBank lutInst (
        .clkDS     (clkDS),
        .rst       (rst),
        .winValid  (winValid),
        .winReady  (winReady),
        .window    (window),
        .partValid (partValid),
        .partReady (partReady),
        .partSums  (partSums)
    );

    adderTree treeInst (
        .clkDS     (clkDS),
        .rst       (rst),
        .partValid (partValid),
        .partReady (partReady),
        .partSums  (partSums),
        .sumValid  (sumValid),
        .sumReady  (sumReady),
        .total     (total)
    );

    outputFormatter formatterInst (
        .clkDS    (clkDS),
        .rst      (rst),
        .sumValid (sumValid),
        .sumReady (sumReady),
        .total    (total),
        .outReq   (outReq),
        .outAck   (outAck),
        .outData  (outData)
    );

endmodule

`default_nettype wire

// File: design/firDecimator_config.svh
`ifndef FIRDECIMATOR_CONFIG_SVH
`define FIRDECIMATOR_CONFIG_SVH

// Filter length, also the number of history bits
`define TAPS 16

// New input bits per output sample
`define OSR 4

// Window bits per lookup group
`define LUT_SIZE 4

`define COEF_WIDTH 8
`define SUM_WIDTH 12
`define OUT_WIDTH 8

// Arithmetic right shift before saturation
`define OUT_SHIFT 2

`endif

// File: design/firPkg.sv
`default_nettype none

`include "firDecimator_config.svh"

package firPkg;

    typedef logic signed [`COEF_WIDTH-1:0] coefT;
    typedef logic signed [`SUM_WIDTH-1:0] sumT;

    // Bit 0 holds the newest bit
    typedef logic [`TAPS-1:0] windowT;

    // Offset-binary result
    typedef logic [`OUT_WIDTH-1:0] outT;

    localparam int NUM_GROUPS = `TAPS / `LUT_SIZE;

    // Symmetric lowpass, coefficients sum to 544
    localparam coefT coefTable [`TAPS] = '{
        3, 7, 14, 25, 38, 52, 63, 70,
        70, 63, 52, 38, 25, 14, 7, 3
    };

endpackage

`default_nettype wire

// File: design/lutBank.sv
`timescale 1ns/1ns
`default_nettype none

`include "firDecimator_config.svh"

module lutBank
    import firPkg::*;
(
    input  logic   clkDS,
    input  logic   rst,
    input  logic   winValid,
    output logic   winReady,
    input  windowT window,
    output logic   partValid,
    input  logic   partReady,
    output sumT    partSums [NUM_GROUPS]
);

    // Signed sum of +/- coefficients for one bit pattern of a group
    function automatic sumT groupEntry(int group, int pattern);
        sumT acc;
        coefT coef;
        acc = '0;
        for (int b = 0; b < `LUT_SIZE; b++) begin
            coef = coefTable[group * `LUT_SIZE + b];
            if (pattern[b]) begin
                acc = acc + sumT'(coef);
            end else begin
                acc = acc - sumT'(coef);
            end
        end
        return acc;
    endfunction

    sumT lookup [NUM_GROUPS];

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : genGroup
        sumT lutTable [2**`LUT_SIZE];

        // Constant table, folded to ROM
        for (genvar p = 0; p < 2**`LUT_SIZE; p++) begin : genEntry
            assign lutTable[p] = groupEntry(g, p);
        end

        assign lookup[g] = lutTable[window[g*`LUT_SIZE +: `LUT_SIZE]];
    end

    // Output register is free or being drained
    assign winReady = !partValid || partReady;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            partValid <= 1'b0;
        end else if (winReady) begin
            partValid <= winValid;
        end
    end

    always_ff @(posedge clkDS) begin
        if (winValid && winReady) begin
            partSums <= lookup;
        end
    end

endmodule

`default_nettype wire

// File: design/outputFormatter.sv
`timescale 1ns/1ns
`default_nettype none

`include "firDecimator_config.svh"

module outputFormatter
    import firPkg::*;
(
    input  logic clkDS,
    input  logic rst,
    input  logic sumValid,
    output logic sumReady,
    input  sumT  total,
    output logic outReq,
    input  logic outAck,
    output outT  outData
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RELEASE
    } stateT;

    localparam sumT SAT_MAX = sumT'((1 <<< (`OUT_WIDTH - 1)) - 1);
    localparam sumT SAT_MIN = sumT'(-(1 <<< (`OUT_WIDTH - 1)));

    stateT state;
    sumT shifted;
    logic signed [`OUT_WIDTH-1:0] clipped;
    outT formatted;

    always_comb begin
        shifted = total >>> `OUT_SHIFT;
        if (shifted > SAT_MAX) begin
            clipped = SAT_MAX[`OUT_WIDTH-1:0];
        end else if (shifted < SAT_MIN) begin
            clipped = SAT_MIN[`OUT_WIDTH-1:0];
        end else begin
            clipped = shifted[`OUT_WIDTH-1:0];
        end
        // Two's complement to offset binary
        formatted = {~clipped[`OUT_WIDTH-1], clipped[`OUT_WIDTH-2:0]};
    end

    assign sumReady = (state == IDLE);
    assign outReq = (state == REQUEST);

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (sumValid) state <= REQUEST;
                REQUEST: if (outAck) state <= RELEASE;
                RELEASE: if (!outAck) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Only loaded while idle, so stable during the request
    always_ff @(posedge clkDS) begin
        if (sumValid && sumReady) begin
            outData <= formatted;
        end
    end

endmodule

`default_nettype wire

// File: firDecimator.f
+incdir+design
design/firPkg.sv
design/bitCollector.sv
design/lutBank.sv
design/adderTree.sv
design/outputFormatter.sv
design/firDecimator.sv
testbench/firDecimator_asserts.sv
testbench/firDecimatorTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the firDecimator testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module firDecimatorTb -f firDecimator.f -o firDecimatorSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/firDecimatorSim > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: testbench/firDecimatorTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "firDecimator_config.svh"

module firDecimatorTb
    import firPkg::*;
();

    localparam int WAIT_LIMIT = 2000;
    localparam int DRIVE_DELAY = 2;

    logic clkDS;
    logic rst;
    logic bitReq;
    logic bitData;
    logic bitAck;
    logic outReq;
    logic outAck;
    outT  outData;

    // Reference model state
    windowT refWindow;
    int acceptedBits = 0;
    int resultCount = 0;
    int errorCount = 0;
    outT expectedQ [$];
    outT gotResults [$];
    logic outReqSeen = 1'b0;

    logic [31:0] bitRng = 32'd58;
    logic [31:0] delayRng;
    int ackMin = 0;
    int ackSpan = 0;

    firDecimator firDecimator_inst (
        .clkDS   (clkDS),
        .rst     (rst),
        .bitReq  (bitReq),
        .bitData (bitData),
        .bitAck  (bitAck),
        .outReq  (outReq),
        .outAck  (outAck),
        .outData (outData)
    );

    always #20 clkDS = ~clkDS;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Filter rule: +coef for a 1, -coef for a 0, shift, clip, flip MSB
    function automatic outT refFilter(input windowT win);
        int total;
        int scaled;
        int maxVal;
        outT result;
        total = 0;
        maxVal = (1 << (`OUT_WIDTH - 1)) - 1;
        for (int k = 0; k < `TAPS; k++) begin
            if (win[k]) begin
                total = total + int'(coefTable[k]);
            end else begin
                total = total - int'(coefTable[k]);
            end
        end
        scaled = total >>> `OUT_SHIFT;
        if (scaled > maxVal) begin
            scaled = maxVal;
        end else if (scaled < -maxVal - 1) begin
            scaled = -maxVal - 1;
        end
        result = outT'(scaled);
        result[`OUT_WIDTH-1] = ~result[`OUT_WIDTH-1];
        return result;
    endfunction

    function automatic int pickDelay();
        delayRng = xorshift32(delayRng);
        if (ackSpan > 0) begin
            return ackMin + int'(delayRng % 32'(ackSpan));
        end
        return ackMin;
    endfunction

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkOut(input outT got, input outT expected, input string what);
        if (got !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            abortRun();
        end
    endtask

    task automatic checkCount(input int got, input int expected, input string what);
        if (got != expected) begin
            errorCount++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            abortRun();
        end
    endtask

    // Mirror of the history window, queues a result at each decimation point
    task automatic acceptBit(input logic b);
        refWindow = {refWindow[`TAPS-2:0], b};
        acceptedBits++;
        if (acceptedBits >= `TAPS && (acceptedBits - `TAPS) % `OSR == 0) begin
            expectedQ.push_back(refFilter(refWindow));
        end
    endtask

    task automatic waitBitAck(input logic level);
        int cycles;
        cycles = 0;
        while (bitAck !== level) begin
            @(posedge clkDS);
            #(DRIVE_DELAY);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: bitAck never went to %0b", level);
                abortRun();
            end
        end
    endtask

    task automatic waitOutReq(input logic level);
        int cycles;
        cycles = 0;
        while (outReq !== level) begin
            @(posedge clkDS);
            #(DRIVE_DELAY);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: outReq never went to %0b", level);
                abortRun();
            end
        end
    endtask

    task automatic sendBit(input logic b);
        bitData = b;
        bitReq = 1'b1;
        waitBitAck(1'b1);
        acceptBit(b);
        bitReq = 1'b0;
        waitBitAck(1'b0);
    endtask

    task automatic sendRandom(input int count);
        for (int i = 0; i < count; i++) begin
            bitRng = xorshift32(bitRng);
            sendBit(bitRng[0]);
        end
    endtask

    task automatic sendConst(input logic b, input int count);
        for (int i = 0; i < count; i++) begin
            sendBit(b);
        end
    endtask

    // Consumer side of the output handshake
    initial begin : consumer
        int delay;
        outAck = 1'b0;
        forever begin
            @(posedge clkDS);
            #(DRIVE_DELAY);
            if (rst && outReq) begin
                delay = pickDelay();
                for (int i = 0; i < delay; i++) begin
                    @(posedge clkDS);
                    #(DRIVE_DELAY);
                end
                outAck = 1'b1;
                waitOutReq(1'b0);
                outAck = 1'b0;
            end
        end
    end

    // One compare per rising outReq
    always @(negedge clkDS) begin : compareResults
        outT expected;
        if (rst && outReq && !outReqSeen) begin
            if (acceptedBits < `TAPS) begin
                $display("A result appeared before the window was filled");
                abortRun();
            end else begin
                gotResults.push_back(outData);
                // A surplus result is only counted
                if (expectedQ.size() != 0) begin
                    expected = expectedQ.pop_front();
                    checkOut(outData, expected, $sformatf("result %0d", resultCount));
                end
                resultCount++;
            end
        end
        outReqSeen = outReq;
    end

    // Handshake assertion failures end the run
    always @(negedge clkDS) begin : watchAsserts
        if (firDecimator_inst.assertsInst.failCount != 0) begin
            $display("A handshake assertion failed");
            abortRun();
        end
    end

    initial begin : mainSequence
        int expectedCount;
        int onesIndex;
        int zerosIndex;
        int cycles;
        clkDS = 1'b0;
        rst = 1'b0;
        bitReq = 1'b0;
        bitData = 1'b0;
        refWindow = '0;
        delayRng = xorshift32(32'd58);

        repeat (10) begin
            @(posedge clkDS);
            #(DRIVE_DELAY);
            if (bitAck !== 1'b0 || outReq !== 1'b0) begin
                $display("bitAck or outReq is not low during reset");
                abortRun();
            end
        end
        rst = 1'b1;

        // Random stream, moderate consumer
        ackMin = 1;
        ackSpan = 8;
        sendRandom(60);

        // Segments end on decimation points (bits 84 and 108)
        sendConst(1'b1, 24);
        onesIndex = (acceptedBits - `TAPS) / `OSR;
        sendConst(1'b0, 24);
        zerosIndex = (acceptedBits - `TAPS) / `OSR;

        // Slow consumer holds outAck back
        ackMin = 20;
        ackSpan = 40;
        sendRandom(40);

        // Immediate ack, back-to-back bits
        ackMin = 0;
        ackSpan = 0;
        sendRandom(80);

        expectedCount = (acceptedBits - `TAPS) / `OSR + 1;
        cycles = 0;
        while (expectedQ.size() != 0) begin
            @(posedge clkDS);
            #(DRIVE_DELAY);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: only %0d of %0d results arrived", resultCount, expectedCount);
                abortRun();
            end
        end

        checkCount(resultCount, expectedCount, "result count");
        checkOut(gotResults[onesIndex], outT'(8'hFF), "all-ones result");
        checkOut(gotResults[zerosIndex], outT'(8'h00), "all-zeros result");

        if (errorCount == 0 && firDecimator_inst.assertsInst.failCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/firDecimator_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module firDecimator_asserts
    import firPkg::*;
(
    input logic clkDS,
    input logic rst,
    input logic bitReq,
    input logic bitAck,
    input logic outReq,
    input logic outAck,
    input outT  outData
);

    int failCount = 0;

    // Ack answers a request sampled at the previous edge
    ackNeedsReq: assert property (@(posedge clkDS) disable iff (!rst)
        $rose(bitAck) |-> $past(bitReq))
        else begin
            $error("bitAck rose without bitReq");
            failCount++;
        end

    holdOutData: assert property (@(posedge clkDS) disable iff (!rst)
        (outReq && $past(outReq)) |-> $stable(outData))
        else begin
            $error("outData changed while outReq was high");
            failCount++;
        end

    reqUntilAck: assert property (@(posedge clkDS) disable iff (!rst)
        $fell(outReq) |-> $past(outAck))
        else begin
            $error("outReq fell before outAck rose");
            failCount++;
        end

endmodule

bind firDecimator firDecimator_asserts assertsInst (
    .clkDS   (clkDS),
    .rst     (rst),
    .bitReq  (bitReq),
    .bitAck  (bitAck),
    .outReq  (outReq),
    .outAck  (outAck),
    .outData (outData)
);

`default_nettype wire
